// File: flist.f
src/rhythm_pkg.sv
src/sdram_client_if.sv
src/arbiter_sdram.sv
src/i2s_streamer.sv
src/line_fetcher.sv
src/rhythm_mem_top.sv
verif/sdram_bridge_model.sv
verif/tb_rhythm_mem.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_rhythm_mem
FLIST      := flist.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -Wno-fatal -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := *** TEST PASSED ***
SIM_BIN    := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

$(SIM_BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation ok"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/tb_rhythm_mem.sv
// step table drives host writes, line fetches and audio; expected data from a shadow copy and the fill rule
`default_nettype none

module tb_rhythm_mem;

	timeunit 1ns;
	timeprecision 100ps;

	typedef enum logic [2:0] {
		OP_WRITE, OP_FETCH, OP_PIX, OP_AUDIO_ON, OP_AUDIO_WAIT, OP_DELAY, OP_STARVE
	} op_t;

	typedef struct packed {
		op_t          op;
		logic [31:0]  arg;   // address, row, column, word count or delay
		logic [127:0] data;  // write data only
	} step_t;

	// ========================================
	// wait kinds and table constants
	// ========================================
	localparam int W_HOST_ACK  = 0;
	localparam int W_LINE_DONE = 1;
	localparam int W_AUDIO     = 2;
	localparam int W_UNDERRUN  = 3;
	localparam int W_ZERO      = 4;
	localparam int ROW5  = int'(rhythm_pkg::FB_BASE) + 5 * rhythm_pkg::LINE_WORDS;
	localparam int ROW12 = int'(rhythm_pkg::FB_BASE) + 12 * rhythm_pkg::LINE_WORDS;

	logic MAX10_CLK1_50;
	logic reset_i;
	logic host_wr_i;
	rhythm_pkg::sdram_addr_t host_addr_i;
	rhythm_pkg::sdram_word_t host_wrdata_i;
	logic host_ack_o;
	logic audio_en_i;
	logic i2s_sclk_o;
	logic i2s_lrclk_o;
	logic i2s_dout_o;
	logic audio_underrun_o;
	logic line_req_i;
	rhythm_pkg::line_idx_t line_i;
	logic line_done_o;
	rhythm_pkg::pix_x_t pix_x_i;
	rhythm_pkg::pixel_t pix_o;
	rhythm_pkg::sdram_addr_t bridge_addr_o;
	rhythm_pkg::sdram_word_t bridge_wrdata_o;
	logic bridge_read_o;
	logic bridge_write_o;
	logic bridge_ack_i;
	rhythm_pkg::sdram_word_t bridge_rddata_i;
	int forced_delay;

	rhythm_pkg::sdram_word_t shadow_mem [rhythm_pkg::sdram_addr_t];  // what the host wrote
	step_t steps[$];
	int shown_row = 0;       // row on display
	int host_writes = 0;
	int host_acks = 0;
	int audio_bits = 0;      // rising bit clocks since enable
	int words_played = 0;
	int words_target = 0;
	int zero_bits_left = 0;
	bit audio_check_on = 1'b0;
	bit sclk_prev = 1'b0;
	logic [15:0] sample_acc;

	rhythm_mem_top DUT (.*);

	sdram_bridge_model u_bridge (
		.MAX10_CLK1_50 (MAX10_CLK1_50),
		.reset_i       (reset_i),
		.read_i        (bridge_read_o),
		.write_i       (bridge_write_o),
		.addr_i        (bridge_addr_o),
		.wrdata_i      (bridge_wrdata_o),
		.delay_i       (forced_delay),
		.ack_o         (bridge_ack_i),
		.rddata_o      (bridge_rddata_i)
	);

	initial
	begin
		MAX10_CLK1_50 = 1'b0;
		forever #50 MAX10_CLK1_50 = ~MAX10_CLK1_50;
	end

	// ========================================
	// reporting and expected values
	// ========================================
	task automatic abort_run(string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_value(string name, logic [127:0] expected, logic [127:0] actual);
		if (actual !== expected)
			abort_run($sformatf("Mismatch at %0d ns: %s expected %0h actual %0h",
				$time, name, expected, actual));
	endtask

	function automatic rhythm_pkg::sdram_word_t expected_word(rhythm_pkg::sdram_addr_t a);
		rhythm_pkg::sdram_word_t w;
		if (shadow_mem.exists(a))
			return shadow_mem[a];
		for (int k = 0; k < 8; k++)  // default fill from the address
			w[16*k +: 16] = (a[15:0] + 16'(k)) ^ {a[21:16], 10'b0};
		return w;
	endfunction

	function automatic rhythm_pkg::pixel_t expected_pixel(int row, int x);
		rhythm_pkg::sdram_word_t w;
		w = expected_word(rhythm_pkg::sdram_addr_t'(int'(rhythm_pkg::FB_BASE)
			+ row * rhythm_pkg::LINE_WORDS + x / 8));
		return w[16*(x % 8) +: 16];
	endfunction

	// sample s of loop word n counted from the top
	function automatic rhythm_pkg::sample_t audio_sample(int n, int s);
		rhythm_pkg::sdram_word_t w;
		w = expected_word(rhythm_pkg::AUDIO_BASE
			+ rhythm_pkg::sdram_addr_t'(n % rhythm_pkg::AUDIO_WORDS));
		return w[127 - 16*s -: 16];
	endfunction

	function automatic bit cond_met(int kind);
		case (kind)
			W_HOST_ACK:  return host_ack_o;
			W_LINE_DONE: return line_done_o;
			W_AUDIO:     return words_played >= words_target;
			W_UNDERRUN:  return audio_underrun_o;
			default:     return zero_bits_left == 0;
		endcase
	endfunction

	task automatic wait_for(int kind, int limit, string what);
		int n;
		n = 0;
		@(negedge MAX10_CLK1_50);
		while (!cond_met(kind))
		begin
			if (n >= limit)
				abort_run({"Timeout: ", what, " did not arrive"});
			else
			begin
				n++;
				@(negedge MAX10_CLK1_50);
			end
		end
	endtask

	// ========================================
	// monitors
	// ========================================
	always @(negedge MAX10_CLK1_50)
	begin
		if (!reset_i)
		begin
			check_value("bridge_read_o & bridge_write_o", '0,
				128'(bridge_read_o & bridge_write_o));
			if (host_ack_o)
				host_acks++;
		end
	end

	always @(negedge MAX10_CLK1_50)
	begin
		int pos;
		pos = audio_bits % 128;  // bit within the word
		if (!audio_en_i)
			audio_bits = 0;
		else if (i2s_sclk_o && !sclk_prev)  // rising bit clock
		begin
			sample_acc = {sample_acc[14:0], i2s_dout_o};
			if (audio_check_on)
			begin
				// odd = right
				check_value("i2s_lrclk_o", 128'((pos / 16) % 2), 128'(i2s_lrclk_o));
				check_value("audio_underrun_o", '0, 128'(audio_underrun_o));
				if (pos % 16 == 15)
					check_value("i2s_dout_o sample",
						128'(audio_sample(audio_bits / 128, pos / 16)),
						128'(sample_acc));
			end
			if (zero_bits_left > 0)
			begin
				check_value("i2s_dout_o", '0, 128'(i2s_dout_o));
				zero_bits_left--;
			end
			if (pos == 127)
				words_played++;
			audio_bits++;
		end
		sclk_prev = i2s_sclk_o;
	end

	// ========================================
	// step table
	// ========================================
	task automatic add_step(op_t op, int arg, rhythm_pkg::sdram_word_t data);
		step_t st;
		st.op   = op;
		st.arg  = arg;
		st.data = data;
		steps.push_back(st);
	endtask

	task automatic fill_table();
		int row5_cols[8];
		row5_cols = '{0, 3, 7, 8, 13, 100, 315, 319};
		add_step(OP_WRITE, ROW5, 128'h7777_6666_5555_4444_3333_2222_1111_0aaa);
		add_step(OP_WRITE, ROW5 + 1, 128'h1f1f_2e2e_3d3d_4c4c_5b5b_6a6a_7979_8888);
		add_step(OP_WRITE, ROW5 + 39, 128'hdead_beef_cafe_f00d_0123_4567_89ab_cdef);
		add_step(OP_WRITE, int'(rhythm_pkg::AUDIO_BASE) + 1,
			128'h8001_7ffe_4000_c000_1234_edcb_00ff_ff00);
		add_step(OP_FETCH, 5, '0);
		foreach (row5_cols[i])
			add_step(OP_PIX, row5_cols[i], '0);
		add_step(OP_FETCH, 7, '0);  // unwritten row shows the fill pattern
		add_step(OP_PIX, 0, '0);
		add_step(OP_PIX, 161, '0);
		add_step(OP_FETCH, 9, '0);  // bank swap
		add_step(OP_PIX, 2, '0);
		add_step(OP_PIX, 319, '0);
		add_step(OP_AUDIO_ON, 0, '0);
		// under audio
		add_step(OP_WRITE, ROW12 + 4, 128'h0f0e_0d0c_0b0a_0908_0706_0504_0302_0100);
		add_step(OP_FETCH, 12, '0);
		add_step(OP_PIX, 37, '0);
		add_step(OP_WRITE, ROW5 + 2, 128'ha5a5_5a5a_c3c3_3c3c_9696_6969_f0f0_0f0f);
		add_step(OP_FETCH, 5, '0);
		add_step(OP_PIX, 17, '0);
		add_step(OP_PIX, 8, '0);
		add_step(OP_AUDIO_WAIT, 18, '0);  // past the loop wrap
		add_step(OP_DELAY, 3000, '0);
		add_step(OP_STARVE, 0, '0);
	endtask

	task automatic run_step(step_t st);
		case (st.op)
			OP_WRITE:
			begin
				@(posedge MAX10_CLK1_50);
				#10;
				host_wr_i     = 1'b1;
				host_addr_i   = rhythm_pkg::sdram_addr_t'(st.arg);
				host_wrdata_i = st.data;
				wait_for(W_HOST_ACK, 500, "host_ack_o");
				@(posedge MAX10_CLK1_50);
				#10;
				host_wr_i = 1'b0;
				shadow_mem[host_addr_i] = st.data;
				host_writes++;
				check_value("host_ack_o count", 128'(host_writes), 128'(host_acks));
			end
			OP_FETCH:
			begin
				@(posedge MAX10_CLK1_50);
				#10;
				line_req_i = 1'b1;
				line_i     = rhythm_pkg::line_idx_t'(st.arg);
				@(posedge MAX10_CLK1_50);
				#10;
				line_req_i = 1'b0;
				wait_for(W_LINE_DONE, 3000, "line_done_o");
				shown_row = st.arg;
			end
			OP_PIX:
			begin
				@(posedge MAX10_CLK1_50);
				#10;
				pix_x_i = rhythm_pkg::pix_x_t'(st.arg);
				@(posedge MAX10_CLK1_50);  // registered pixel
				@(negedge MAX10_CLK1_50);
				check_value("pix_o", 128'(expected_pixel(shown_row, st.arg)), 128'(pix_o));
			end
			OP_AUDIO_ON:
			begin
				@(posedge MAX10_CLK1_50);
				#10;
				audio_en_i     = 1'b1;
				audio_check_on = 1'b1;
			end
			OP_AUDIO_WAIT:
			begin
				words_target = st.arg;
				wait_for(W_AUDIO, st.arg * 2100 + 2000, "played audio words");
			end
			OP_DELAY: forced_delay = st.arg;
			default:
			begin
				audio_check_on = 1'b0;  // from here a silent word is expected
				wait_for(W_UNDERRUN, 20000, "audio_underrun_o");
				check_value("audio word boundary", '0, 128'(audio_bits % 128));
				zero_bits_left = 128;
				wait_for(W_ZERO, 2500, "silent audio word");
			end
		endcase
	endtask

	initial
	begin
		void'($urandom(87345));
		reset_i       = 1'b1;
		host_wr_i     = 1'b0;
		host_addr_i   = '0;
		host_wrdata_i = '0;
		audio_en_i    = 1'b0;
		line_req_i    = 1'b0;
		line_i        = '0;
		pix_x_i       = '0;
		forced_delay  = 0;
		fill_table();
		repeat (3) @(posedge MAX10_CLK1_50);
		#10;
		reset_i = 1'b0;
		@(negedge MAX10_CLK1_50);
		check_value("bridge_read_o", '0, 128'(bridge_read_o));
		check_value("bridge_write_o", '0, 128'(bridge_write_o));
		check_value("host_ack_o", '0, 128'(host_ack_o));
		check_value("line_done_o", '0, 128'(line_done_o));
		check_value("audio_underrun_o", '0, 128'(audio_underrun_o));
		check_value("i2s_sclk_o", '0, 128'(i2s_sclk_o));
		check_value("i2s_lrclk_o", '0, 128'(i2s_lrclk_o));
		check_value("i2s_dout_o", '0, 128'(i2s_dout_o));
		foreach (steps[i])
			run_step(steps[i]);
		check_value("host_ack_o count", 128'(host_writes), 128'(host_acks));
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/sdram_bridge_model.sv
// bridge memory model; unwritten words read back an address pattern, ack after 1..5 cycles or a forced delay
`default_nettype none

module sdram_bridge_model (
	input  logic                    MAX10_CLK1_50,
	input  logic                    reset_i,
	input  logic                    read_i,
	input  logic                    write_i,
	input  rhythm_pkg::sdram_addr_t addr_i,
	input  rhythm_pkg::sdram_word_t wrdata_i,
	input  int                      delay_i,   // 0 picks a random delay
	output logic                    ack_o,
	output rhythm_pkg::sdram_word_t rddata_o
);

	timeunit 1ns;
	timeprecision 100ps;

	rhythm_pkg::sdram_word_t mem_q [rhythm_pkg::sdram_addr_t];  // written words only
	logic busy = 1'b0;
	int   wait_cnt = 0;

	// lane k is the low address plus k, upper address bits folded into the top
	function automatic rhythm_pkg::sdram_word_t fill_word(rhythm_pkg::sdram_addr_t a);
		rhythm_pkg::sdram_word_t w;
		for (int k = 0; k < 8; k++)
			w[16*k +: 16] = (a[15:0] + 16'(k)) ^ {a[21:16], 10'b0};
		return w;
	endfunction

	initial
	begin
		ack_o    = 1'b0;
		rddata_o = '0;
	end

	always @(posedge MAX10_CLK1_50)
	begin
		if (reset_i)
		begin
			ack_o <= 1'b0;
			busy  <= 1'b0;
		end
		else if (ack_o)
			ack_o <= 1'b0;  // command is dropped on this edge
		else if (busy)
		begin
			if (wait_cnt <= 1)
			begin
				ack_o <= 1'b1;
				busy  <= 1'b0;
				if (write_i)
					mem_q[addr_i] = wrdata_i;
				else
					rddata_o <= mem_q.exists(addr_i) ? mem_q[addr_i] : fill_word(addr_i);
			end
			else
				wait_cnt <= wait_cnt - 1;
		end
		else if (read_i || write_i)
		begin
			busy     <= 1'b1;
			wait_cnt <= (delay_i > 0) ? delay_i : int'($urandom_range(5, 1));
		end
	end

endmodule

`default_nettype wire

// File: src/rhythm_mem_top.sv
// memory side only; the sdram controller sits outside behind the bridge ports, host port is write only
`default_nettype none

module rhythm_mem_top (
	input  logic                    MAX10_CLK1_50,
	input  logic                    reset_i,

	// host write port, stands in for the sd loader
	input  logic                    host_wr_i,
	input  rhythm_pkg::sdram_addr_t host_addr_i,
	input  rhythm_pkg::sdram_word_t host_wrdata_i,
	output logic                    host_ack_o,

	// audio codec
	input  logic                    audio_en_i,
	output logic                    i2s_sclk_o,
	output logic                    i2s_lrclk_o,
	output logic                    i2s_dout_o,
	output logic                    audio_underrun_o,

	// display line buffer
	input  logic                    line_req_i,
	input  rhythm_pkg::line_idx_t   line_i,
	output logic                    line_done_o,
	input  rhythm_pkg::pix_x_t      pix_x_i,
	output rhythm_pkg::pixel_t      pix_o,

	// sdram bridge
	output rhythm_pkg::sdram_addr_t bridge_addr_o,
	output rhythm_pkg::sdram_word_t bridge_wrdata_o,
	output logic                    bridge_read_o,
	output logic                    bridge_write_o,
	input  logic                    bridge_ack_i,
	input  rhythm_pkg::sdram_word_t bridge_rddata_i
);

	// ========================================
	// client ports
	// ========================================
	sdram_client_if host_if ();
	sdram_client_if audio_if ();
	sdram_client_if line_if ();

	// host never reads, its rddata stays unused
	assign host_if.rd     = 1'b0;
	assign host_if.wr     = host_wr_i;
	assign host_if.addr   = host_addr_i;
	assign host_if.wrdata = host_wrdata_i;
	assign host_ack_o     = host_if.ack;

	arbiter_sdram u_arbiter (
		.MAX10_CLK1_50   (MAX10_CLK1_50),
		.reset_i         (reset_i),
		.host_c          (host_if),   // highest priority
		.audio_c         (audio_if),
		.line_c          (line_if),
		.bridge_addr_o   (bridge_addr_o),
		.bridge_wrdata_o (bridge_wrdata_o),
		.bridge_read_o   (bridge_read_o),
		.bridge_write_o  (bridge_write_o),
		.bridge_ack_i    (bridge_ack_i),
		.bridge_rddata_i (bridge_rddata_i)
	);

	i2s_streamer u_i2s (
		.MAX10_CLK1_50    (MAX10_CLK1_50),
		.reset_i          (reset_i),
		.audio_en_i       (audio_en_i),
		.mem              (audio_if),
		.i2s_sclk_o       (i2s_sclk_o),
		.i2s_lrclk_o      (i2s_lrclk_o),
		.i2s_dout_o       (i2s_dout_o),
		.audio_underrun_o (audio_underrun_o)
	);

	line_fetcher u_line (
		.MAX10_CLK1_50 (MAX10_CLK1_50),
		.reset_i       (reset_i),
		.line_req_i    (line_req_i),
		.line_i        (line_i),
		.mem           (line_if),
		.line_done_o   (line_done_o),
		.pix_x_i       (pix_x_i),
		.pix_o         (pix_o)
	);

endmodule

`default_nettype wire

// File: src/line_fetcher.sv
// one row at a time into a ping-pong buffer; pix_x_i above 319 reads outside the line
`default_nettype none

module line_fetcher (
	input  logic                  MAX10_CLK1_50,
	input  logic                  reset_i,
	input  logic                  line_req_i,
	input  rhythm_pkg::line_idx_t line_i,
	sdram_client_if.client        mem,
	output logic                  line_done_o,
	input  rhythm_pkg::pix_x_t    pix_x_i,
	output rhythm_pkg::pixel_t    pix_o
);

	// two banks of one line each
	rhythm_pkg::sdram_word_t line_mem [2][rhythm_pkg::LINE_WORDS];

	rhythm_pkg::sdram_addr_t row_addr;   // first word of the row
	rhythm_pkg::line_word_t  word_cnt;   // word being read
	logic                    rd_q;       // high for the whole fetch
	logic                    show_bank;  // bank seen by the display
	logic                    last_word;

	assign last_word = (word_cnt == rhythm_pkg::line_word_t'(rhythm_pkg::LINE_WORDS - 1));

	assign mem.rd     = rd_q;
	assign mem.wr     = 1'b0;
	assign mem.addr   = row_addr + rhythm_pkg::sdram_addr_t'(word_cnt);
	assign mem.wrdata = '0;

	// ========================================
	// read sequence
	// ========================================
	always_ff @(posedge MAX10_CLK1_50)
	begin
		if (reset_i)
		begin
			rd_q        <= 1'b0;
			show_bank   <= 1'b0;
			word_cnt    <= '0;
			line_done_o <= 1'b0;
		end
		else
		begin
			line_done_o <= 1'b0;
			if (!rd_q && line_req_i)  // requests during a fetch are dropped
			begin
				rd_q     <= 1'b1;
				word_cnt <= '0;
			end
			else if (mem.ack)
			begin
				if (last_word)
				begin
					rd_q        <= 1'b0;
					show_bank   <= ~show_bank;  // new line goes on display
					line_done_o <= 1'b1;
				end
				else
					word_cnt <= word_cnt + 1'b1;  // next address at once
			end
		end
	end

	// row base, fb + row * 40
	always_ff @(posedge MAX10_CLK1_50)
	begin
		if (!rd_q && line_req_i)
			row_addr <= rhythm_pkg::FB_BASE + rhythm_pkg::sdram_addr_t'(line_i)
				* rhythm_pkg::sdram_addr_t'(rhythm_pkg::LINE_WORDS);
	end

	// fill the bank that is not displayed
	always_ff @(posedge MAX10_CLK1_50)
	begin
		if (mem.ack)
			line_mem[~show_bank][word_cnt] <= mem.rddata;
	end

	// pixel k of a word in bits 16k+15:16k, one cycle late
	always_ff @(posedge MAX10_CLK1_50)
	begin
		pix_o <= line_mem[show_bank][pix_x_i[8:3]][{pix_x_i[2:0], 4'b0000} +: 16];
	end

endmodule

`default_nettype wire

// File: src/i2s_streamer.sv
// left-justified out, left channel while lrclk is low; starts only once a word is fetched, no mclk
`default_nettype none

module i2s_streamer (
	input  logic            MAX10_CLK1_50,
	input  logic            reset_i,
	input  logic            audio_en_i,
	sdram_client_if.client  mem,
	output logic            i2s_sclk_o,
	output logic            i2s_lrclk_o,
	output logic            i2s_dout_o,
	output logic            audio_underrun_o
);

	rhythm_pkg::sclk_cnt_t   div_cnt;     // system clocks within half a bit
	logic [4:0]              bit_cnt;     // bit within a l/r frame
	logic [1:0]              frame_cnt;   // l/r pair within a word
	logic [4:0]              bit_nxt;
	logic                    primed;      // serializer running
	logic                    half_tick;
	logic                    fall_tick;
	logic                    word_end;
	logic                    word_start;
	rhythm_pkg::sdram_word_t shreg;       // playing word, msb goes out next
	rhythm_pkg::sdram_word_t pf_word;     // prefetched next word
	logic                    pf_valid;
	logic                    rd_q;
	rhythm_pkg::sdram_addr_t fetch_addr;

	assign half_tick  = primed && (div_cnt == rhythm_pkg::sclk_cnt_t'(rhythm_pkg::SCLK_HALF - 1));
	assign fall_tick  = half_tick && i2s_sclk_o;  // sclk about to drop
	assign word_end   = (bit_cnt == 5'd31)
		&& (frame_cnt == 2'(rhythm_pkg::SAMPLES_PER_WORD / 2 - 1));
	assign word_start = (audio_en_i && !primed && pf_valid) || (fall_tick && word_end);
	assign bit_nxt    = bit_cnt + 5'd1;

	// fetch side of the client port, read only
	assign mem.rd     = rd_q;
	assign mem.wr     = 1'b0;
	assign mem.addr   = fetch_addr;
	assign mem.wrdata = '0;

	// ========================================
	// bit clock, word select, serial data
	// ========================================
	always_ff @(posedge MAX10_CLK1_50)
	begin
		if (reset_i || !audio_en_i)
		begin
			div_cnt     <= '0;
			primed      <= 1'b0;
			i2s_sclk_o  <= 1'b0;
			i2s_lrclk_o <= 1'b0;
			i2s_dout_o  <= 1'b0;
			bit_cnt     <= '0;
			frame_cnt   <= '0;
		end
		else
		begin
			if (half_tick)
			begin
				div_cnt    <= '0;
				i2s_sclk_o <= ~i2s_sclk_o;
			end
			else if (primed)
				div_cnt <= div_cnt + 1'b1;

			if (word_start)
			begin
				primed      <= 1'b1;
				bit_cnt     <= '0;
				frame_cnt   <= '0;
				i2s_lrclk_o <= 1'b0;  // first sample is left
				i2s_dout_o  <= pf_valid ? pf_word[127] : 1'b0;
			end
			else if (fall_tick)
			begin
				bit_cnt     <= bit_nxt;
				i2s_lrclk_o <= bit_nxt[4];  // flips together with the next msb
				i2s_dout_o  <= shreg[126];
				if (bit_cnt == 5'd31)
					frame_cnt <= frame_cnt + 1'b1;
			end
		end
	end

	// shifter and prefetch store
	always_ff @(posedge MAX10_CLK1_50)
	begin
		if (word_start)
			shreg <= pf_valid ? pf_word
				: {rhythm_pkg::SAMPLES_PER_WORD{rhythm_pkg::sample_t'('0)}};  // silence
		else if (fall_tick)
			shreg <= {shreg[126:0], 1'b0};
		if (mem.ack)
			pf_word <= mem.rddata;
	end

	// ========================================
	// prefetch control
	// ========================================
	always_ff @(posedge MAX10_CLK1_50)
	begin
		if (reset_i)
		begin
			pf_valid         <= 1'b0;
			rd_q             <= 1'b0;
			fetch_addr       <= rhythm_pkg::AUDIO_BASE;
			audio_underrun_o <= 1'b0;
		end
		else
		begin
			if (word_start && !pf_valid)
				audio_underrun_o <= 1'b1;  // sticky
			if (mem.ack)
			begin
				pf_valid   <= 1'b1;
				rd_q       <= 1'b0;
				fetch_addr <= (fetch_addr == rhythm_pkg::AUDIO_LAST) ? rhythm_pkg::AUDIO_BASE
					: fetch_addr + 1'b1;
			end
			else
			begin
				if (word_start)
					pf_valid <= 1'b0;  // handed to the shifter
				if (!rd_q && (!pf_valid || word_start))
					rd_q <= 1'b1;  // ask for the next one right away
			end
		end
	end

endmodule

`default_nettype wire

// File: src/arbiter_sdram.sv
// fixed priority host > audio > line; a starved low client simply waits, ack passes through combinationally
`default_nettype none

module arbiter_sdram (
	input  logic                    MAX10_CLK1_50,
	input  logic                    reset_i,
	sdram_client_if.arbiter         host_c,
	sdram_client_if.arbiter         audio_c,
	sdram_client_if.arbiter         line_c,
	output rhythm_pkg::sdram_addr_t bridge_addr_o,
	output rhythm_pkg::sdram_word_t bridge_wrdata_o,
	output logic                    bridge_read_o,
	output logic                    bridge_write_o,
	input  logic                    bridge_ack_i,
	input  rhythm_pkg::sdram_word_t bridge_rddata_i
);

	typedef enum logic {
		ST_IDLE,
		ST_BUSY
	} arb_state_t;

	arb_state_t state_q;

	logic host_req;
	logic audio_req;
	logic line_req;
	logic any_req;

	// winner of this cycle, one hot host/audio/line
	logic [2:0]              sel_grant;
	logic                    sel_rd;
	logic                    sel_wr;
	rhythm_pkg::sdram_addr_t sel_addr;
	rhythm_pkg::sdram_word_t sel_wrdata;

	logic [2:0] grant_q;  // latched owner of the bridge

	assign host_req  = host_c.rd | host_c.wr;
	assign audio_req = audio_c.rd | audio_c.wr;
	assign line_req  = line_c.rd | line_c.wr;
	assign any_req   = host_req | audio_req | line_req;

	// ========================================
	// priority select
	// ========================================
	always_comb
	begin
		sel_grant  = 3'b000;
		sel_rd     = 1'b0;
		sel_wr     = 1'b0;
		sel_addr   = line_c.addr;  // lowest priority as fallback
		sel_wrdata = line_c.wrdata;
		if (host_req)
		begin
			sel_grant  = 3'b001;
			sel_rd     = host_c.rd;
			sel_wr     = host_c.wr;
			sel_addr   = host_c.addr;
			sel_wrdata = host_c.wrdata;
		end
		else if (audio_req)
		begin
			sel_grant  = 3'b010;
			sel_rd     = audio_c.rd;
			sel_wr     = audio_c.wr;
			sel_addr   = audio_c.addr;
			sel_wrdata = audio_c.wrdata;
		end
		else if (line_req)
		begin
			sel_grant = 3'b100;
			sel_rd    = line_c.rd;
			sel_wr    = line_c.wr;
		end
	end

	// ========================================
	// grant fsm and bridge command
	// ========================================
	always_ff @(posedge MAX10_CLK1_50)
	begin
		if (reset_i)
		begin
			state_q        <= ST_IDLE;
			bridge_read_o  <= 1'b0;
			bridge_write_o <= 1'b0;
		end
		else
		begin
			case (state_q)
				ST_IDLE:
				begin
					if (any_req)
					begin
						state_q        <= ST_BUSY;
						bridge_read_o  <= sel_rd & ~sel_wr;  // write wins a bad request
						bridge_write_o <= sel_wr;
					end
				end
				ST_BUSY:
				begin
					// command held until the bridge answers
					if (bridge_ack_i)
					begin
						state_q        <= ST_IDLE;
						bridge_read_o  <= 1'b0;
						bridge_write_o <= 1'b0;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// owner, address and data only change when a new access starts
	always_ff @(posedge MAX10_CLK1_50)
	begin
		if (state_q == ST_IDLE && any_req)
		begin
			grant_q         <= sel_grant;
			bridge_addr_o   <= sel_addr;
			bridge_wrdata_o <= sel_wrdata;
		end
	end

	// response goes only to the owner
	assign host_c.ack     = (state_q == ST_BUSY) && grant_q[0] && bridge_ack_i;
	assign audio_c.ack    = (state_q == ST_BUSY) && grant_q[1] && bridge_ack_i;
	assign line_c.ack     = (state_q == ST_BUSY) && grant_q[2] && bridge_ack_i;
	assign host_c.rddata  = grant_q[0] ? bridge_rddata_i : '0;
	assign audio_c.rddata = grant_q[1] ? bridge_rddata_i : '0;
	assign line_c.rddata  = grant_q[2] ? bridge_rddata_i : '0;

endmodule

`default_nettype wire

// File: src/sdram_client_if.sv
// one client of the sdram bridge; rd and wr are never high together and are held until ack
`default_nettype none

interface sdram_client_if;

	// request side, owned by the client
	logic                      rd;      // read level
	logic                      wr;      // write level
	rhythm_pkg::sdram_addr_t   addr;    // word address, stable while requesting
	rhythm_pkg::sdram_word_t   wrdata;  // full word, no byte enables

	// response side, owned by the arbiter
	logic                      ack;     // one cycle pulse, ends the access
	rhythm_pkg::sdram_word_t   rddata;  // valid only with ack

	// client drops or replaces its request the cycle after ack
	modport client (
		output rd,
		output wr,
		output addr,
		output wrdata,
		input  ack,
		input  rddata
	);

	// arbiter sees every client the same way
	modport arbiter (
		input  rd,
		input  wr,
		input  addr,
		input  wrdata,
		output ack,
		output rddata
	);

endinterface

`default_nettype wire

// File: src/rhythm_pkg.sv
// memory map, audio and line constants; AUDIO_WORDS is sized for simulation and needs raising on hardware
`default_nettype none

package rhythm_pkg;

	// ========================================
	// bridge and payload widths
	// ========================================
	typedef logic [21:0]  sdram_addr_t;  // one unit per 128-bit word
	typedef logic [127:0] sdram_word_t;
	typedef logic [15:0]  sample_t;      // sent msb first
	typedef logic [15:0]  pixel_t;
	typedef logic [8:0]   line_idx_t;    // frame buffer row
	typedef logic [8:0]   pix_x_t;       // column within a row

	// ========================================
	// memory map
	// ========================================
	localparam sdram_addr_t AUDIO_BASE = 22'h20_0000;
	localparam int AUDIO_WORDS = 16;  // loop length before wrapping
	// last word of the loop, wrap point for the streamer
	localparam sdram_addr_t AUDIO_LAST = AUDIO_BASE + sdram_addr_t'(AUDIO_WORDS - 1);
	localparam sdram_addr_t FB_BASE = 22'h01_0000;

	// 320 pixels at 8 per word
	localparam int LINE_WORDS = 40;
	typedef logic [$clog2(LINE_WORDS)-1:0] line_word_t;

	// ========================================
	// audio timing
	// ========================================
	localparam int SAMPLES_PER_WORD = 8;  // 4 left/right pairs
	localparam int SCLK_HALF = 8;         // system clocks per half bit clock
	typedef logic [$clog2(SCLK_HALF)-1:0] sclk_cnt_t;

endpackage

`default_nettype wire
